// File: bench/hazardCases.txt
# instrF iDataOk exceptionValid isEret stall flushD flushE flushM flushW fwdAD fwdBD fwdAE fwdBE
# Forward codes: 0 none, 1 ALUSRCAE, 2 ALUOUTM, 3 RESULTW, 4 HIM, 5 LOM, 6 HIW, 7 LOW.
00000000 1 0 0 0 0 0 0 0 0 0 0 0
00000000 0 0 0 1 0 1 0 0 0 0 0 0
34010005 1 0 0 0 0 0 0 0 0 0 0 0 # ori r1, r0, 5
00201021 1 0 0 0 0 0 0 0 0 0 0 0 # addu r2, r1, r0
00221821 1 0 0 0 0 0 0 0 0 0 0 0 # addu r3, r1, r2
34000001 1 0 0 0 0 0 0 0 2 0 2 0 # ori r0, r0, 1
00002821 1 0 0 0 0 0 0 0 0 0 3 2 # addu r5, r0, r0
00000000 1 0 0 0 0 0 0 0 0 0 0 0
00000000 1 0 0 0 0 0 0 0 0 0 0 0
8c280000 1 0 0 0 0 0 0 0 0 0 0 0 # lw r8, 0(r1)
01014821 1 0 0 0 0 0 0 0 0 0 0 0 # addu r9, r8, r1
00000000 1 0 0 1 0 1 0 0 0 0 0 0
00000000 1 0 0 0 0 0 0 0 2 0 0 0
00000000 1 0 0 0 0 0 0 0 0 0 3 0
00225021 1 0 0 0 0 0 0 0 0 0 0 0 # addu r10, r1, r2
11400004 1 0 0 0 0 0 0 0 0 0 0 0 # beq r10, r0
00000000 1 0 0 1 0 1 0 0 0 0 0 0
00000000 1 0 0 0 0 0 0 0 2 0 0 0
00000000 1 0 0 0 0 0 0 0 0 0 3 0
00005810 1 0 0 0 0 0 0 0 0 0 0 0 # mfhi r11
11600004 1 0 0 0 0 0 0 0 0 0 0 0 # beq r11, r0
00000000 1 0 0 0 0 0 0 0 1 0 0 0
00000000 1 0 0 0 0 0 0 0 0 0 2 0
00220018 1 0 0 0 0 0 0 0 0 0 0 0 # mult r1, r2
00006010 1 0 0 0 0 0 0 0 0 0 0 0 # mfhi r12
00006812 1 0 0 0 0 0 0 0 0 0 0 0 # mflo r13
00000000 1 0 0 0 0 0 0 0 0 0 4 0
00000000 1 0 0 0 0 0 0 0 0 0 7 0
00640018 1 0 0 0 0 0 0 0 0 0 0 0 # mult r3, r4
00006812 1 0 0 0 0 0 0 0 0 0 0 0 # mflo r13
00006010 1 0 0 0 0 0 0 0 0 0 0 0 # mfhi r12
00000000 1 0 0 0 0 0 0 0 0 0 5 0
00000000 1 0 0 0 0 0 0 0 0 0 6 0
40816000 1 0 0 0 0 0 0 0 0 0 0 0 # mtc0 r1, $12
400e6000 1 0 0 0 0 0 0 0 0 0 0 0 # mfc0 r14, $12
00000000 1 0 0 0 0 0 0 0 0 0 0 0
00000000 1 0 0 0 0 0 0 0 0 0 2 0
00201021 1 0 0 0 0 0 0 0 0 0 0 0 # addu r2, r1, r0
00221821 1 0 0 0 0 0 0 0 0 0 0 0 # addu r3, r1, r2
34010005 1 0 0 0 0 0 0 0 0 0 0 0 # ori r1, r0, 5
00000000 1 1 0 0 1 1 1 1 0 0 0 2 # exception
00000000 1 0 0 0 0 0 0 0 0 0 0 0
34010005 1 0 0 0 0 0 0 0 0 0 0 0 # ori r1, r0, 5
00201021 1 0 0 0 0 0 0 0 0 0 0 0 # addu r2, r1, r0
00221821 1 0 0 0 0 0 0 0 0 0 0 0 # addu r3, r1, r2
00000000 1 0 1 0 1 1 1 0 2 0 2 0 # eret
00000000 1 0 0 0 0 0 0 0 0 0 0 0

// File: hazardUnit.f
design/mipsPkg.sv
design/instrDecode.sv
design/stageRegs.sv
design/forwardUnit.sv
design/stallDetect.sv
design/pipeControl.sv
design/hazardTop.sv
bench/hazardTop_sva.sv
bench/hazardTb.sv

// File: run.sh
#!/bin/sh
# Builds the hazard unit testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f hazardUnit.f --top-module hazardTb -o hazardSim

./obj_dir/hazardSim | tee sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
    echo "run.sh: testbench reported success"
    exit 0
else
    echo "run.sh: testbench did not report success, see sim.log"
    exit 1
fi

// File: bench/hazardTb.sv
`default_nettype none
`timescale 1ns/100ps

module hazardTb;

    localparam int    HALF_PERIOD    = 10;
    localparam int    PERIOD         = 2 * HALF_PERIOD;
    localparam int    RESET_CYCLES   = 8;
    localparam int    FIELD_COUNT    = 13;
    localparam int    TIMEOUT_MARGIN = 20;
    localparam string CASE_FILE      = "bench/hazardCases.txt";

    // One clock cycle of stimulus and the outputs expected before the next edge.
    typedef struct packed {
        logic [mipsPkg::WORD_W-1:0] instr;
        logic                       iDataOk;
        logic                       exceptionValid;
        logic                       isEret;
        logic [4:0]                 flags;
        logic [2:0]                 fwdAD;
        logic [2:0]                 fwdBD;
        logic [2:0]                 fwdAE;
        logic [2:0]                 fwdBE;
    } caseT;

    logic                       clk;
    logic                       rst;
    logic [mipsPkg::WORD_W-1:0] instrF;
    logic                       iDataOk;
    logic                       exceptionValid;
    logic                       isEret;
    logic                       stall;
    logic                       flushD;
    logic                       flushE;
    logic                       flushM;
    logic                       flushW;
    mipsPkg::forwardSelT        forwardAD;
    mipsPkg::forwardSelT        forwardBD;
    mipsPkg::forwardSelT        forwardAE;
    mipsPkg::forwardSelT        forwardBE;
    caseT                       cases[$];
    logic                       loaded;
    int                         errors;
    int                         checks;

    hazardTop dut (
        .clk(clk), .rst(rst), .instrF(instrF), .iDataOk(iDataOk),
        .exceptionValid(exceptionValid), .isEret(isEret), .stall(stall),
        .flushD(flushD), .flushE(flushE), .flushM(flushM), .flushW(flushW),
        .forwardAD(forwardAD), .forwardBD(forwardBD),
        .forwardAE(forwardAE), .forwardBE(forwardBE)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic readCases();
        int          fd;
        int          fieldsRead;
        int          lineNo;
        string       line;
        logic [31:0] f [FIELD_COUNT];
        caseT        c;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the case file %s", CASE_FILE);
            errors++;
            return;
        end
        lineNo = 0;
        while ($fgets(line, fd) != 0) begin
            lineNo++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fieldsRead = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                 f[7], f[8], f[9], f[10], f[11], f[12]);
            if (fieldsRead != FIELD_COUNT) begin
                $display("Case file line %0d holds %0d of %0d fields",
                         lineNo, fieldsRead, FIELD_COUNT);
                errors++;
            end else begin
                c.instr          = f[0];
                c.iDataOk        = f[1][0];
                c.exceptionValid = f[2][0];
                c.isEret         = f[3][0];
                c.flags          = {f[4][0], f[5][0], f[6][0], f[7][0], f[8][0]};
                c.fwdAD          = f[9][2:0];
                c.fwdBD          = f[10][2:0];
                c.fwdAE          = f[11][2:0];
                c.fwdBE          = f[12][2:0];
                cases.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    task automatic compareOutput(input int caseNo, input string name,
                                 input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %0t: case %0d %s expected %0d, got %0d",
                     $realtime, caseNo, name, expected, actual);
        end
    endtask

    task automatic applyCase(input caseT c);
        instrF         = c.instr;
        iDataOk        = c.iDataOk;
        exceptionValid = c.exceptionValid;
        isEret         = c.isEret;
    endtask

    task automatic checkCase(input int caseNo, input caseT c);
        compareOutput(caseNo, "stall", int'(c.flags[4]), int'(stall));
        compareOutput(caseNo, "flushD", int'(c.flags[3]), int'(flushD));
        compareOutput(caseNo, "flushE", int'(c.flags[2]), int'(flushE));
        compareOutput(caseNo, "flushM", int'(c.flags[1]), int'(flushM));
        compareOutput(caseNo, "flushW", int'(c.flags[0]), int'(flushW));
        compareOutput(caseNo, "forwardAD", int'(c.fwdAD), int'(forwardAD));
        compareOutput(caseNo, "forwardBD", int'(c.fwdBD), int'(forwardBD));
        compareOutput(caseNo, "forwardAE", int'(c.fwdAE), int'(forwardAE));
        compareOutput(caseNo, "forwardBE", int'(c.fwdBE), int'(forwardBE));
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        instrF         = '0;
        iDataOk        = 1'b1;
        exceptionValid = 1'b0;
        isEret         = 1'b0;
        errors         = 0;
        checks         = 0;
        loaded         = 1'b0;
        readCases();
        loaded = 1'b1;
        if (cases.size() == 0) begin
            $display("No usable cases were found in %s", CASE_FILE);
            errors++;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            // Inputs change on the falling edge and outputs settle before the rising one.
            foreach (cases[i]) begin
                applyCase(cases[i]);
                #(HALF_PERIOD - 1);
                checkCase(i, cases[i]);
                @(negedge clk);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        int limitNs;
        wait (loaded);
        limitNs = (cases.size() + TIMEOUT_MARGIN) * PERIOD;
        #(limitNs);
        $display("Watchdog expired after %0d ns before the case loop finished", limitNs);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/hazardTop_sva.sv
`default_nettype none
`timescale 1ns/100ps

module hazardTopSva (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flushD,
    input logic flushE,
    input logic flushM,
    input logic flushW
);

    // A held D stage must send a bubble into E.
    stallFlushesE: assert property (@(posedge clk) disable iff (rst) stall |-> flushE)
        else $error("stall is high while flushE is low");

    redirectFlushesM: assert property (@(posedge clk) disable iff (rst) flushD |-> flushM)
        else $error("flushD is high while flushM is low");

    // Only an exception clears W, and it clears D as well.
    exceptionFlushesD: assert property (@(posedge clk) disable iff (rst) flushW |-> flushD)
        else $error("flushW is high while flushD is low");

endmodule

bind hazardTop hazardTopSva sva (
    .clk(clk), .rst(rst), .stall(stall),
    .flushD(flushD), .flushE(flushE), .flushM(flushM), .flushW(flushW)
);

`default_nettype wire

// File: design/hazardTop.sv
`default_nettype none
`timescale 1ns/100ps

module hazardTop (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [mipsPkg::WORD_W-1:0] instrF,
    input  logic                       iDataOk,
    input  logic                       exceptionValid,
    input  logic                       isEret,
    output logic                       stall,
    output logic                       flushD,
    output logic                       flushE,
    output logic                       flushM,
    output logic                       flushW,
    output mipsPkg::forwardSelT        forwardAD,
    output mipsPkg::forwardSelT        forwardBD,
    output mipsPkg::forwardSelT        forwardAE,
    output mipsPkg::forwardSelT        forwardBE
);

    logic [mipsPkg::WORD_W-1:0]     instrD;
    logic [mipsPkg::WORD_W-1:0]     instrE;
    logic [mipsPkg::WORD_W-1:0]     instrM;
    logic [mipsPkg::WORD_W-1:0]     instrW;
    logic [mipsPkg::REG_ADDR_W-1:0] rsD;
    logic [mipsPkg::REG_ADDR_W-1:0] rtD;
    logic [mipsPkg::REG_ADDR_W-1:0] rsE;
    logic [mipsPkg::REG_ADDR_W-1:0] rtE;
    logic [mipsPkg::REG_ADDR_W-1:0] writeRegE;
    logic [mipsPkg::REG_ADDR_W-1:0] writeRegM;
    logic [mipsPkg::REG_ADDR_W-1:0] writeRegW;
    mipsPkg::decodedOpT             opD;
    mipsPkg::aluFuncT               aluFuncE;
    logic                           branchD;
    logic                           jrD;
    logic                           regWriteE;
    logic                           regWriteM;
    logic                           regWriteW;
    logic                           memToRegE;
    logic                           memToRegM;
    logic                           hiToRegE;
    logic                           loToRegE;
    logic                           cp0ToRegE;
    logic                           hiWriteM;
    logic                           loWriteM;
    logic                           cp0WriteM;
    logic                           hiWriteW;
    logic                           loWriteW;
    logic                           cp0WriteW;
    logic                           loadUseStall;
    logic                           branchStall;

    stageRegs stages (
        .clk(clk), .rst(rst), .instrF(instrF), .stall(stall),
        .flushD(flushD), .flushE(flushE), .flushM(flushM), .flushW(flushW),
        .instrD(instrD), .instrE(instrE), .instrM(instrM), .instrW(instrW)
    );

    instrDecode decD (
        .instr(instrD), .rs(rsD), .rt(rtD), .writeReg(), .op(opD), .aluFunc(),
        .regWrite(), .memToReg(), .branch(branchD), .jr(jrD),
        .hiWrite(), .loWrite(), .cp0Write(), .hiToReg(), .loToReg(), .cp0ToReg()
    );

    instrDecode decE (
        .instr(instrE), .rs(rsE), .rt(rtE), .writeReg(writeRegE), .op(),
        .aluFunc(aluFuncE), .regWrite(regWriteE), .memToReg(memToRegE),
        .branch(), .jr(), .hiWrite(), .loWrite(), .cp0Write(),
        .hiToReg(hiToRegE), .loToReg(loToRegE), .cp0ToReg(cp0ToRegE)
    );

    instrDecode decM (
        .instr(instrM), .rs(), .rt(), .writeReg(writeRegM), .op(), .aluFunc(),
        .regWrite(regWriteM), .memToReg(memToRegM), .branch(), .jr(),
        .hiWrite(hiWriteM), .loWrite(loWriteM), .cp0Write(cp0WriteM),
        .hiToReg(), .loToReg(), .cp0ToReg()
    );

    instrDecode decW (
        .instr(instrW), .rs(), .rt(), .writeReg(writeRegW), .op(), .aluFunc(),
        .regWrite(regWriteW), .memToReg(), .branch(), .jr(),
        .hiWrite(hiWriteW), .loWrite(loWriteW), .cp0Write(cp0WriteW),
        .hiToReg(), .loToReg(), .cp0ToReg()
    );

    forwardUnit forward (
        .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
        .writeRegE(writeRegE), .regWriteE(regWriteE), .aluFuncE(aluFuncE),
        .hiToRegE(hiToRegE), .loToRegE(loToRegE), .cp0ToRegE(cp0ToRegE),
        .writeRegM(writeRegM), .regWriteM(regWriteM),
        .hiWriteM(hiWriteM), .loWriteM(loWriteM), .cp0WriteM(cp0WriteM),
        .writeRegW(writeRegW), .regWriteW(regWriteW),
        .hiWriteW(hiWriteW), .loWriteW(loWriteW), .cp0WriteW(cp0WriteW),
        .forwardAD(forwardAD), .forwardBD(forwardBD),
        .forwardAE(forwardAE), .forwardBE(forwardBE)
    );

    stallDetect stallCheck (
        .rsD(rsD), .rtD(rtD), .opD(opD), .branchD(branchD), .jrD(jrD),
        .rtE(rtE), .writeRegE(writeRegE), .regWriteE(regWriteE),
        .memToRegE(memToRegE), .aluFuncE(aluFuncE),
        .writeRegM(writeRegM), .memToRegM(memToRegM),
        .loadUseStall(loadUseStall), .branchStall(branchStall)
    );

    pipeControl control (
        .loadUseStall(loadUseStall), .branchStall(branchStall), .iDataOk(iDataOk),
        .exceptionValid(exceptionValid), .isEret(isEret), .stall(stall),
        .flushD(flushD), .flushE(flushE), .flushM(flushM), .flushW(flushW)
    );

endmodule

`default_nettype wire

// File: design/pipeControl.sv
`default_nettype none
`timescale 1ns/100ps

module pipeControl (
    input  logic loadUseStall,
    input  logic branchStall,
    input  logic iDataOk,
    input  logic exceptionValid,
    input  logic isEret,
    output logic stall,
    output logic flushD,
    output logic flushE,
    output logic flushM,
    output logic flushW
);

    logic redirect;

    // F and D hold together; E takes a bubble behind them.
    assign stall = loadUseStall || branchStall || !iDataOk;

    assign redirect = exceptionValid || isEret;

    assign flushD = redirect;
    assign flushE = stall || redirect;
    assign flushM = redirect;
    // ERET lets the W instruction retire.
    assign flushW = exceptionValid;

endmodule

`default_nettype wire

// File: design/stallDetect.sv
`default_nettype none
`timescale 1ns/100ps

module stallDetect (
    input  logic [mipsPkg::REG_ADDR_W-1:0] rsD,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rtD,
    input  mipsPkg::decodedOpT             opD,
    input  logic                           branchD,
    input  logic                           jrD,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rtE,
    input  logic [mipsPkg::REG_ADDR_W-1:0] writeRegE,
    input  logic                           regWriteE,
    input  logic                           memToRegE,
    input  mipsPkg::aluFuncT               aluFuncE,
    input  logic [mipsPkg::REG_ADDR_W-1:0] writeRegM,
    input  logic                           memToRegM,
    output logic                           loadUseStall,
    output logic                           branchStall
);

    logic compareD;
    logic rsPending;
    logic rtPending;

    assign loadUseStall = memToRegE && ((rsD == rtE) || (rtD == rtE));

    // BEQ and BNE read rt as well; JR reads rs only.
    assign compareD  = (opD == mipsPkg::BEQ) || (opD == mipsPkg::BNE);
    assign rsPending = (regWriteE && writeRegE == rsD) || (memToRegM && writeRegM == rsD);
    assign rtPending = (regWriteE && writeRegE == rtD) || (memToRegM && writeRegM == rtD);

    // A move-from in E is covered by ALUSRCAE forwarding.
    assign branchStall = (branchD || jrD) && (aluFuncE != mipsPkg::ALU_PASSA) &&
                         (rsPending || (compareD && rtPending));

endmodule

`default_nettype wire

// File: design/forwardUnit.sv
`default_nettype none
`timescale 1ns/100ps

module forwardUnit (
    input  logic [mipsPkg::REG_ADDR_W-1:0] rsD,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rtD,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rsE,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rtE,
    input  logic [mipsPkg::REG_ADDR_W-1:0] writeRegE,
    input  logic                           regWriteE,
    input  mipsPkg::aluFuncT               aluFuncE,
    input  logic                           hiToRegE,
    input  logic                           loToRegE,
    input  logic                           cp0ToRegE,
    input  logic [mipsPkg::REG_ADDR_W-1:0] writeRegM,
    input  logic                           regWriteM,
    input  logic                           hiWriteM,
    input  logic                           loWriteM,
    input  logic                           cp0WriteM,
    input  logic [mipsPkg::REG_ADDR_W-1:0] writeRegW,
    input  logic                           regWriteW,
    input  logic                           hiWriteW,
    input  logic                           loWriteW,
    input  logic                           cp0WriteW,
    output mipsPkg::forwardSelT            forwardAD,
    output mipsPkg::forwardSelT            forwardBD,
    output mipsPkg::forwardSelT            forwardAE,
    output mipsPkg::forwardSelT            forwardBE
);

    logic multM;
    logic multW;
    logic specialM;
    logic specialW;

    // Only MULT writes HI and LO together.
    assign multM = hiWriteM && loWriteM;
    assign multW = hiWriteW && loWriteW;

    assign specialM = (hiWriteM && hiToRegE) || (loWriteM && loToRegE) ||
                      (cp0WriteM && cp0ToRegE);
    assign specialW = (hiWriteW && hiToRegE) || (loWriteW && loToRegE) ||
                      (cp0WriteW && cp0ToRegE);

    function automatic logic hitM(input logic [mipsPkg::REG_ADDR_W-1:0] src);
        return (src != '0) && regWriteM && (src == writeRegM);
    endfunction

    function automatic logic hitW(input logic [mipsPkg::REG_ADDR_W-1:0] src);
        return (src != '0) && regWriteW && (src == writeRegW);
    endfunction

    // Branch compare operands in D; E can only supply a move-from result.
    function automatic mipsPkg::forwardSelT selectD(input logic [mipsPkg::REG_ADDR_W-1:0] src);
        if (src != '0 && regWriteE && src == writeRegE && aluFuncE == mipsPkg::ALU_PASSA) begin
            return mipsPkg::ALUSRCAE;
        end else if (hitM(src)) begin
            return mipsPkg::ALUOUTM;
        end else if (hitW(src)) begin
            return mipsPkg::RESULTW;
        end
        return mipsPkg::NOFORWARD;
    endfunction

    always_comb begin
        forwardAD = selectD(rsD);
        forwardBD = selectD(rtD);
    end

    always_comb begin
        if (multM && hiToRegE) begin
            forwardAE = mipsPkg::HIM;
        end else if (multM && loToRegE) begin
            forwardAE = mipsPkg::LOM;
        end else if (specialM || hitM(rsE)) begin
            forwardAE = mipsPkg::ALUOUTM;
        end else if (multW && hiToRegE) begin
            forwardAE = mipsPkg::HIW;
        end else if (multW && loToRegE) begin
            forwardAE = mipsPkg::LOW;
        end else if (specialW || hitW(rsE)) begin
            forwardAE = mipsPkg::RESULTW;
        end else begin
            forwardAE = mipsPkg::NOFORWARD;
        end
    end

    always_comb begin
        if (hitM(rtE)) begin
            forwardBE = mipsPkg::ALUOUTM;
        end else if (hitW(rtE)) begin
            forwardBE = mipsPkg::RESULTW;
        end else begin
            forwardBE = mipsPkg::NOFORWARD;
        end
    end

endmodule

`default_nettype wire

// File: design/stageRegs.sv
`default_nettype none
`timescale 1ns/100ps

module stageRegs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [mipsPkg::WORD_W-1:0] instrF,
    input  logic                       stall,
    input  logic                       flushD,
    input  logic                       flushE,
    input  logic                       flushM,
    input  logic                       flushW,
    output logic [mipsPkg::WORD_W-1:0] instrD,
    output logic [mipsPkg::WORD_W-1:0] instrE,
    output logic [mipsPkg::WORD_W-1:0] instrM,
    output logic [mipsPkg::WORD_W-1:0] instrW
);

    // A flush in D wins over a stall, so the redirect is never lost.
    always_ff @(posedge clk) begin
        if (rst || flushD) begin
            instrD <= '0;
        end else if (!stall) begin
            instrD <= instrF;
        end
    end

    // Later stages never hold; a flush turns them into a bubble.
    always_ff @(posedge clk) begin
        if (rst || flushE) begin
            instrE <= '0;
        end else begin
            instrE <= instrD;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flushM) begin
            instrM <= '0;
        end else begin
            instrM <= instrE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flushW) begin
            instrW <= '0;
        end else begin
            instrW <= instrM;
        end
    end

endmodule

`default_nettype wire

// File: design/instrDecode.sv
`default_nettype none
`timescale 1ns/100ps

module instrDecode (
    input  logic [mipsPkg::WORD_W-1:0]     instr,
    output logic [mipsPkg::REG_ADDR_W-1:0] rs,
    output logic [mipsPkg::REG_ADDR_W-1:0] rt,
    output logic [mipsPkg::REG_ADDR_W-1:0] writeReg,
    output mipsPkg::decodedOpT             op,
    output mipsPkg::aluFuncT               aluFunc,
    output logic                           regWrite,
    output logic                           memToReg,
    output logic                           branch,
    output logic                           jr,
    output logic                           hiWrite,
    output logic                           loWrite,
    output logic                           cp0Write,
    output logic                           hiToReg,
    output logic                           loToReg,
    output logic                           cp0ToReg
);

    logic [mipsPkg::FIELD6_W-1:0]   opcode;
    logic [mipsPkg::FIELD6_W-1:0]   funct;
    logic [mipsPkg::REG_ADDR_W-1:0] rd;

    assign opcode = instr[mipsPkg::OP_MSB -: mipsPkg::FIELD6_W];
    assign funct  = instr[mipsPkg::FN_MSB -: mipsPkg::FIELD6_W];
    assign rs     = instr[mipsPkg::RS_LSB +: mipsPkg::REG_ADDR_W];
    assign rt     = instr[mipsPkg::RT_LSB +: mipsPkg::REG_ADDR_W];
    assign rd     = instr[mipsPkg::RD_LSB +: mipsPkg::REG_ADDR_W];

    always_comb begin
        op = mipsPkg::NOP;
        case (opcode)
            mipsPkg::OPC_SPECIAL: begin
                case (funct)
                    mipsPkg::FN_ADDU: op = mipsPkg::ADDU;
                    mipsPkg::FN_SUBU: op = mipsPkg::SUBU;
                    mipsPkg::FN_OR:   op = mipsPkg::OR;
                    mipsPkg::FN_JR:   op = mipsPkg::JR;
                    mipsPkg::FN_MULT: op = mipsPkg::MULT;
                    mipsPkg::FN_MFHI: op = mipsPkg::MFHI;
                    mipsPkg::FN_MFLO: op = mipsPkg::MFLO;
                    mipsPkg::FN_MTHI: op = mipsPkg::MTHI;
                    mipsPkg::FN_MTLO: op = mipsPkg::MTLO;
                    default:          op = mipsPkg::NOP;
                endcase
            end
            mipsPkg::OPC_ORI: op = mipsPkg::ORI;
            mipsPkg::OPC_LUI: op = mipsPkg::LUI;
            mipsPkg::OPC_LW:  op = mipsPkg::LW;
            mipsPkg::OPC_SW:  op = mipsPkg::SW;
            mipsPkg::OPC_BEQ: op = mipsPkg::BEQ;
            mipsPkg::OPC_BNE: op = mipsPkg::BNE;
            mipsPkg::OPC_COP0: begin
                if (rs == mipsPkg::CP0_MF) begin
                    op = mipsPkg::MFC0;
                end else if (rs == mipsPkg::CP0_MT) begin
                    op = mipsPkg::MTC0;
                end else if (rs == mipsPkg::CP0_CO && funct == mipsPkg::FN_ERET) begin
                    op = mipsPkg::ERET;
                end
            end
            default: op = mipsPkg::NOP;
        endcase
    end

    always_comb begin
        case (op)
            mipsPkg::SUBU, mipsPkg::BEQ, mipsPkg::BNE:   aluFunc = mipsPkg::ALU_SUB;
            mipsPkg::OR, mipsPkg::ORI:                   aluFunc = mipsPkg::ALU_OR;
            mipsPkg::LUI:                                aluFunc = mipsPkg::ALU_LUI;
            mipsPkg::MFHI, mipsPkg::MFLO, mipsPkg::MFC0: aluFunc = mipsPkg::ALU_PASSA;
            default:                                     aluFunc = mipsPkg::ALU_ADD;
        endcase
    end

    assign regWrite = op inside {mipsPkg::ADDU, mipsPkg::SUBU, mipsPkg::OR, mipsPkg::ORI,
                                 mipsPkg::LUI, mipsPkg::LW, mipsPkg::MFHI, mipsPkg::MFLO,
                                 mipsPkg::MFC0};
    assign memToReg = (op == mipsPkg::LW);
    assign branch   = (op == mipsPkg::BEQ) || (op == mipsPkg::BNE);
    assign jr       = (op == mipsPkg::JR);
    assign hiWrite  = (op == mipsPkg::MULT) || (op == mipsPkg::MTHI);
    assign loWrite  = (op == mipsPkg::MULT) || (op == mipsPkg::MTLO);
    assign cp0Write = (op == mipsPkg::MTC0);
    assign hiToReg  = (op == mipsPkg::MFHI);
    assign loToReg  = (op == mipsPkg::MFLO);
    assign cp0ToReg = (op == mipsPkg::MFC0);

    // I-type writers and MFC0 target rt, R-type writers target rd.
    assign writeReg = !regWrite ? '0 :
                      (op inside {mipsPkg::ORI, mipsPkg::LUI, mipsPkg::LW, mipsPkg::MFC0}) ?
                      rt : rd;

endmodule

`default_nettype wire

// File: design/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int FIELD6_W   = 6;

    // Instruction field positions.
    localparam int OP_MSB = 31;
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;
    localparam int FN_MSB = 5;

    // Primary opcodes.
    localparam logic [FIELD6_W-1:0] OPC_SPECIAL = 6'h00;
    localparam logic [FIELD6_W-1:0] OPC_BEQ     = 6'h04;
    localparam logic [FIELD6_W-1:0] OPC_BNE     = 6'h05;
    localparam logic [FIELD6_W-1:0] OPC_ORI     = 6'h0d;
    localparam logic [FIELD6_W-1:0] OPC_LUI     = 6'h0f;
    localparam logic [FIELD6_W-1:0] OPC_COP0    = 6'h10;
    localparam logic [FIELD6_W-1:0] OPC_LW      = 6'h23;
    localparam logic [FIELD6_W-1:0] OPC_SW      = 6'h2b;

    // SPECIAL funct codes.
    localparam logic [FIELD6_W-1:0] FN_JR   = 6'h08;
    localparam logic [FIELD6_W-1:0] FN_MFHI = 6'h10;
    localparam logic [FIELD6_W-1:0] FN_MTHI = 6'h11;
    localparam logic [FIELD6_W-1:0] FN_MFLO = 6'h12;
    localparam logic [FIELD6_W-1:0] FN_MTLO = 6'h13;
    localparam logic [FIELD6_W-1:0] FN_MULT = 6'h18;
    localparam logic [FIELD6_W-1:0] FN_ADDU = 6'h21;
    localparam logic [FIELD6_W-1:0] FN_SUBU = 6'h23;
    localparam logic [FIELD6_W-1:0] FN_OR   = 6'h25;

    // COP0 sub-opcodes sit in the rs field.
    localparam logic [REG_ADDR_W-1:0] CP0_MF = 5'h00;
    localparam logic [REG_ADDR_W-1:0] CP0_MT = 5'h04;
    localparam logic [REG_ADDR_W-1:0] CP0_CO = 5'h10;
    localparam logic [FIELD6_W-1:0]   FN_ERET = 6'h18;

    typedef enum logic [4:0] {
        NOP, ADDU, SUBU, OR, ORI, LUI, LW, SW, BEQ, BNE,
        JR, MULT, MFHI, MFLO, MTHI, MTLO, MFC0, MTC0, ERET
    } decodedOpT;

    // ALU_PASSA: the result is already operand A in E.
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_OR, ALU_LUI, ALU_PASSA
    } aluFuncT;

    typedef enum logic [2:0] {
        NOFORWARD, ALUSRCAE, ALUOUTM, RESULTW, HIM, LOM, HIW, LOW
    } forwardSelT;

endpackage

`default_nettype wire
